// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Register and bus width
`define CPU_DATA_WIDTH 16

// Instruction word, also the memory word
`define CPU_INSTR_WIDTH 18

// 256 words shared by program and data
`define CPU_ADDR_WIDTH 8

// Register file depth
`define CPU_REG_COUNT 16

`endif

// ==== cpu_pkg.sv ====
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

	// One instruction word, read as register or immediate format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] dest;
			logic [3:0] srcA;
			logic [3:0] srcB;
			logic [1:0] spare;
		} regView;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] dest;
			logic [`CPU_INSTR_WIDTH-9:0] imm;
		} immView;
	} instrWord;

	////////////////////
	// Opcodes
	localparam logic [3:0] OP_ADD  = 4'h0;
	localparam logic [3:0] OP_SUB  = 4'h1;
	localparam logic [3:0] OP_AND  = 4'h2;
	localparam logic [3:0] OP_OR   = 4'h3;
	localparam logic [3:0] OP_XOR  = 4'h4;
	localparam logic [3:0] OP_MOV  = 4'h5;
	localparam logic [3:0] OP_XCH  = 4'h6;
	localparam logic [3:0] OP_LDI  = 4'h7;
	localparam logic [3:0] OP_INC  = 4'h8;
	localparam logic [3:0] OP_DEC  = 4'h9;
	localparam logic [3:0] OP_LD   = 4'hA;
	localparam logic [3:0] OP_ST   = 4'hB;
	localparam logic [3:0] OP_JMP  = 4'hC;
	localparam logic [3:0] OP_BR   = 4'hD;
	localparam logic [3:0] OP_OUT  = 4'hE;
	localparam logic [3:0] OP_HALT = 4'hF;

	////////////////////
	// ALU operations
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;

	////////////////////
	// Write-back sources, port 1
	localparam logic [1:0] WB_ALU    = 2'd0;
	localparam logic [1:0] WB_MEM    = 2'd1;
	localparam logic [1:0] WB_IMM    = 2'd2;
	localparam logic [1:0] WB_INCDEC = 2'd3;

	// Port 2 takes a raw register value
	localparam logic WB2_A = 1'b0;
	localparam logic WB2_B = 1'b1;

endpackage

`default_nettype wire

// ==== alu.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module alu (
	input  wire  [`CPU_DATA_WIDTH-1:0] a,
	input  wire  [`CPU_DATA_WIDTH-1:0] b,
	input  wire  [2:0]                 aluOp,
	output logic [`CPU_DATA_WIDTH-1:0] result,
	output logic                       zero,
	output logic                       negative,
	output logic                       carry,
	output logic                       overflow
);

	import cpu_pkg::*;

	localparam int W = `CPU_DATA_WIDTH;

	logic [W:0] sum;
	logic [W:0] diff;

	assign sum = {1'b0, a} + {1'b0, b};

	// a + ~b + 1, so the top bit is set when there is no borrow
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

	always_comb begin
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			ALU_ADD: begin
				result = sum[W-1:0];
				carry = sum[W];
				overflow = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
			end
			ALU_SUB: begin
				result = diff[W-1:0];
				carry = diff[W];
				overflow = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Zero and negative come from the result for every operation
	assign zero = (result == '0);
	assign negative = result[W-1];

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module registerFile (
	input  wire                               clk50MHz,
	input  wire                               reset,
	input  wire  [$clog2(`CPU_REG_COUNT)-1:0] srcASel,
	input  wire  [$clog2(`CPU_REG_COUNT)-1:0] srcBSel,
	input  wire  [$clog2(`CPU_REG_COUNT)-1:0] destSel,
	input  wire  [$clog2(`CPU_REG_COUNT)-1:0] destSel2,
	input  wire                               regWriteEn,
	input  wire                               regWriteEn2,
	input  wire  [`CPU_DATA_WIDTH-1:0]        writeData,
	input  wire  [`CPU_DATA_WIDTH-1:0]        writeData2,
	output logic [`CPU_DATA_WIDTH-1:0]        regA,
	output logic [`CPU_DATA_WIDTH-1:0]        regB
);

	logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

	// Read ports
	assign regA = regs[srcASel];
	assign regB = regs[srcBSel];

	always_ff @(posedge clk50MHz) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (regWriteEn) begin
				regs[destSel] <= writeData;
			end
			// Second port comes last, so it wins a shared target
			if (regWriteEn2) begin
				regs[destSel2] <= writeData2;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mainMemory.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module mainMemory (
	input  wire                         clk50MHz,
	input  wire                         loadStrobe,
	input  wire  [`CPU_ADDR_WIDTH-1:0]  loadAddr,
	input  wire  [`CPU_INSTR_WIDTH-1:0] loadData,
	input  wire  [`CPU_ADDR_WIDTH-1:0]  instrAddr,
	input  wire                         dataWriteEn,
	input  wire  [`CPU_ADDR_WIDTH-1:0]  dataAddr,
	input  wire  [`CPU_DATA_WIDTH-1:0]  dataIn,
	output logic [`CPU_INSTR_WIDTH-1:0] instruction,
	output logic [`CPU_DATA_WIDTH-1:0]  dataOut
);

	localparam int PadWidth = `CPU_INSTR_WIDTH - `CPU_DATA_WIDTH;

	logic [`CPU_INSTR_WIDTH-1:0] mem [2**`CPU_ADDR_WIDTH];
	logic [`CPU_ADDR_WIDTH-1:0]  portAAddr;

	// Port A is shared by fetch and the program load
	assign portAAddr = loadStrobe ? loadAddr : instrAddr;

	////////////////////
	// Port A and port B
	always_ff @(posedge clk50MHz) begin
		if (loadStrobe) begin
			mem[portAAddr] <= loadData;
		end
		// Port B writes data words zero-extended
		if (dataWriteEn) begin
			mem[dataAddr] <= {{PadWidth{1'b0}}, dataIn};
		end
		instruction <= mem[portAAddr];
		dataOut <= mem[dataAddr][`CPU_DATA_WIDTH-1:0];
	end

endmodule

`default_nettype wire

// ==== busRouter.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module busRouter (
	input  wire  [`CPU_DATA_WIDTH-1:0] regA,
	input  wire  [`CPU_DATA_WIDTH-1:0] regB,
	input  wire  [`CPU_DATA_WIDTH-1:0] aluResult,
	input  wire  [`CPU_DATA_WIDTH-1:0] memData,
	input  wire  [`CPU_DATA_WIDTH-1:0] immValue,
	input  wire  [1:0]                 wbSel,
	input  wire                        wb2Sel,
	input  wire                        incSel,
	output logic [`CPU_DATA_WIDTH-1:0] aluA,
	output logic [`CPU_DATA_WIDTH-1:0] aluB,
	output logic [`CPU_DATA_WIDTH-1:0] writeData,
	output logic [`CPU_DATA_WIDTH-1:0] writeData2
);

	import cpu_pkg::*;

	localparam logic [`CPU_DATA_WIDTH-1:0] One = 1;

	logic [`CPU_DATA_WIDTH-1:0] incValue;
	logic [`CPU_DATA_WIDTH-1:0] decValue;
	logic [`CPU_DATA_WIDTH-1:0] incDecValue;

	// Incrementer and decrementer on the B side
	assign incValue = regB + One;
	assign decValue = regB - One;
	assign incDecValue = incSel ? incValue : decValue;

	// INC and DEC also run regB and one through the ALU, for the flags
	assign aluA = (wbSel == WB_INCDEC) ? regB : regA;
	assign aluB = (wbSel == WB_INCDEC) ? One : regB;

	always_comb begin
		case (wbSel)
			WB_ALU:    writeData = aluResult;
			WB_MEM:    writeData = memData;
			WB_IMM:    writeData = immValue;
			WB_INCDEC: writeData = incDecValue;
			default:   writeData = aluResult;
		endcase
	end

	assign writeData2 = (wb2Sel == WB2_B) ? regB : regA;

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module controlUnit (
	input  wire                               clk50MHz,
	input  wire                               reset,
	input  wire                               startStrobe,
	input  wire  cpu_pkg::instrWord           instruction,
	input  wire  [3:0]                        flags,
	input  wire  [`CPU_DATA_WIDTH-1:0]        regA,
	output logic [`CPU_ADDR_WIDTH-1:0]        instrAddr,
	output logic                              dataWriteEn,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] destSel,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] destSel2,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] srcASel,
	output logic [$clog2(`CPU_REG_COUNT)-1:0] srcBSel,
	output logic                              regWriteEn,
	output logic                              regWriteEn2,
	output logic [2:0]                        aluOp,
	output logic [1:0]                        wbSel,
	output logic                              wb2Sel,
	output logic                              incSel,
	output logic [`CPU_DATA_WIDTH-1:0]        immValue,
	output logic                              outStrobe,
	output logic [`CPU_DATA_WIDTH-1:0]        outData,
	output logic                              halted
);

	import cpu_pkg::*;

	localparam int ImmWidth = `CPU_INSTR_WIDTH - 8;

	localparam logic [2:0] stateIdle    = 3'd0;
	localparam logic [2:0] stateFetch   = 3'd1;
	localparam logic [2:0] stateExecute = 3'd2;
	localparam logic [2:0] stateMemRead = 3'd3;
	localparam logic [2:0] stateHalt    = 3'd4;

	logic [2:0]                 state;
	logic [`CPU_ADDR_WIDTH-1:0] pc;
	logic [3:0]                 flagReg;
	logic [3:0]                 opcode;
	logic [3:0]                 dest;
	logic [ImmWidth-1:0]        imm;
	logic [`CPU_ADDR_WIDTH-1:0] target;
	logic                       branchTaken;
	logic                       updatesFlags;

	// Opcode and dest sit in the same place in both views
	assign opcode = instruction.regView.opcode;
	assign dest = instruction.regView.dest;
	assign imm = instruction.immView.imm;
	assign target = imm[`CPU_ADDR_WIDTH-1:0];

	// Flag index for BR comes from dest: zero, negative, carry, overflow
	assign branchTaken = (opcode == OP_JMP) || ((opcode == OP_BR) && flagReg[dest[1:0]]);
	assign updatesFlags = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_INC, OP_DEC};

	////////////////////
	// Sequencer
	always_ff @(posedge clk50MHz) begin
		if (reset) begin
			state <= stateIdle;
			pc <= '0;
			flagReg <= '0;
		end else begin
			case (state)
				stateIdle, stateHalt: begin
					if (startStrobe) begin
						state <= stateFetch;
						pc <= '0;
					end
				end
				stateFetch: begin
					state <= stateExecute;
				end
				stateExecute: begin
					if (updatesFlags) begin
						flagReg <= flags;
					end
					if (opcode == OP_LD) begin
						state <= stateMemRead;
					end else if (opcode == OP_HALT) begin
						state <= stateHalt;
					end else begin
						state <= stateFetch;
						pc <= branchTaken ? target : pc + 1'b1;
					end
				end
				stateMemRead: begin
					state <= stateFetch;
					pc <= pc + 1'b1;
				end
				default: begin
					state <= stateIdle;
				end
			endcase
		end
	end

	////////////////////
	// Decode
	always_comb begin
		destSel = dest;
		destSel2 = instruction.regView.srcA;
		srcASel = instruction.regView.srcA;
		srcBSel = instruction.regView.srcB;
		regWriteEn = 1'b0;
		regWriteEn2 = 1'b0;
		dataWriteEn = 1'b0;
		aluOp = ALU_ADD;
		wbSel = WB_ALU;
		wb2Sel = WB2_A;
		incSel = 1'b0;
		// Sign-extended, used by LDI
		immValue = {{(`CPU_DATA_WIDTH - ImmWidth){imm[ImmWidth-1]}}, imm};

		if (state == stateExecute) begin
			case (opcode)
				OP_ADD: begin
					regWriteEn = 1'b1;
					aluOp = ALU_ADD;
				end
				OP_SUB: begin
					regWriteEn = 1'b1;
					aluOp = ALU_SUB;
				end
				OP_AND: begin
					regWriteEn = 1'b1;
					aluOp = ALU_AND;
				end
				OP_OR: begin
					regWriteEn = 1'b1;
					aluOp = ALU_OR;
				end
				OP_XOR: begin
					regWriteEn = 1'b1;
					aluOp = ALU_XOR;
				end
				OP_MOV: begin
					regWriteEn2 = 1'b1;
					destSel2 = dest;
					wb2Sel = WB2_A;
				end
				OP_XCH: begin
					// Old srcA rides the immediate bus into dest
					srcBSel = dest;
					regWriteEn = 1'b1;
					wbSel = WB_IMM;
					immValue = regA;
					regWriteEn2 = 1'b1;
					wb2Sel = WB2_B;
				end
				OP_LDI: begin
					regWriteEn = 1'b1;
					wbSel = WB_IMM;
				end
				OP_INC: begin
					regWriteEn = 1'b1;
					wbSel = WB_INCDEC;
					incSel = 1'b1;
					aluOp = ALU_ADD;
				end
				OP_DEC: begin
					regWriteEn = 1'b1;
					wbSel = WB_INCDEC;
					aluOp = ALU_SUB;
				end
				OP_ST: begin
					dataWriteEn = 1'b1;
				end
				default: begin
					regWriteEn = 1'b0;
				end
			endcase
		end else if (state == stateMemRead) begin
			// LD data is back from port B
			regWriteEn = 1'b1;
			wbSel = WB_MEM;
		end
	end

	assign instrAddr = pc;
	assign outStrobe = (state == stateExecute) && (opcode == OP_OUT);
	assign outData = regA;
	assign halted = (state == stateHalt);

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module cpuTop (
	input  wire                         clk50MHz,
	input  wire                         reset,
	input  wire                         loadStrobe,
	input  wire  [`CPU_ADDR_WIDTH-1:0]  loadAddr,
	input  wire  [`CPU_INSTR_WIDTH-1:0] loadData,
	input  wire                         startStrobe,
	output logic                        outStrobe,
	output logic [`CPU_DATA_WIDTH-1:0]  outData,
	output logic                        halted
);

	import cpu_pkg::*;

	instrWord instruction;

	logic [`CPU_ADDR_WIDTH-1:0]        instrAddr;
	logic                              dataWriteEn;
	logic [$clog2(`CPU_REG_COUNT)-1:0] destSel;
	logic [$clog2(`CPU_REG_COUNT)-1:0] destSel2;
	logic [$clog2(`CPU_REG_COUNT)-1:0] srcASel;
	logic [$clog2(`CPU_REG_COUNT)-1:0] srcBSel;
	logic                              regWriteEn;
	logic                              regWriteEn2;
	logic [2:0]                        aluOp;
	logic [1:0]                        wbSel;
	logic                              wb2Sel;
	logic                              incSel;
	logic [`CPU_DATA_WIDTH-1:0]        immValue;

	// Datapath buses
	logic [`CPU_DATA_WIDTH-1:0] regA;
	logic [`CPU_DATA_WIDTH-1:0] regB;
	logic [`CPU_DATA_WIDTH-1:0] aluA;
	logic [`CPU_DATA_WIDTH-1:0] aluB;
	logic [`CPU_DATA_WIDTH-1:0] aluResult;
	logic [`CPU_DATA_WIDTH-1:0] memData;
	logic [`CPU_DATA_WIDTH-1:0] writeData;
	logic [`CPU_DATA_WIDTH-1:0] writeData2;
	logic                       zero;
	logic                       negative;
	logic                       carry;
	logic                       overflow;

	controlUnit masterControl (
		.clk50MHz(clk50MHz), .reset(reset), .startStrobe(startStrobe),
		.instruction(instruction), .flags({overflow, carry, negative, zero}), .regA(regA),
		.instrAddr(instrAddr), .dataWriteEn(dataWriteEn),
		.destSel(destSel), .destSel2(destSel2), .srcASel(srcASel), .srcBSel(srcBSel),
		.regWriteEn(regWriteEn), .regWriteEn2(regWriteEn2),
		.aluOp(aluOp), .wbSel(wbSel), .wb2Sel(wb2Sel), .incSel(incSel), .immValue(immValue),
		.outStrobe(outStrobe), .outData(outData), .halted(halted)
	);

	alu aluInst (
		.a(aluA), .b(aluB), .aluOp(aluOp), .result(aluResult),
		.zero(zero), .negative(negative), .carry(carry), .overflow(overflow)
	);

	registerFile regFile (
		.clk50MHz(clk50MHz), .reset(reset),
		.srcASel(srcASel), .srcBSel(srcBSel), .destSel(destSel), .destSel2(destSel2),
		.regWriteEn(regWriteEn), .regWriteEn2(regWriteEn2),
		.writeData(writeData), .writeData2(writeData2), .regA(regA), .regB(regB)
	);

	// Port A is fetch and load, port B is data addressed by regB
	mainMemory memory (
		.clk50MHz(clk50MHz), .loadStrobe(loadStrobe), .loadAddr(loadAddr), .loadData(loadData),
		.instrAddr(instrAddr), .dataWriteEn(dataWriteEn),
		.dataAddr(regB[`CPU_ADDR_WIDTH-1:0]), .dataIn(regA),
		.instruction(instruction), .dataOut(memData)
	);

	busRouter router (
		.regA(regA), .regB(regB), .aluResult(aluResult), .memData(memData),
		.immValue(immValue), .wbSel(wbSel), .wb2Sel(wb2Sel), .incSel(incSel),
		.aluA(aluA), .aluB(aluB), .writeData(writeData), .writeData2(writeData2)
	);

endmodule

`default_nettype wire

// ==== tbChecker.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module tbChecker (
	input  wire                        clk50MHz,
	input  wire                        reset,
	input  wire                        startStrobe,
	input  wire                        outStrobe,
	input  wire  [`CPU_DATA_WIDTH-1:0] outData,
	input  wire                        halted,
	output int                         errorCount
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0]                patterns [256];
	logic [`CPU_DATA_WIDTH-1:0] expected [$];
	int                         progNum;
	int                         outIndex;
	logic                       wasHalted;
	logic                       wasReset;
	string                      testName;

	initial begin
		$readmemh("cpu_patterns.mem", patterns);
		errorCount = 0;
		progNum = 0;
		outIndex = 0;
		wasHalted = 1'b0;
		wasReset = 1'b0;
		testName = "none";
	end

	// Expected outputs that follow the given program header
	task automatic collectExpected(input int prog);
		int headers;
		logic [3:0] kind;
		headers = 0;
		expected.delete();
		for (int i = 0; i < 256; i++) begin
			kind = patterns[i][31:28];
			if ($isunknown(kind) || kind == 4'h0) begin
				break;
			end
			if (kind == 4'h1) begin
				headers++;
			end else if (kind == 4'h3 && headers == prog) begin
				expected.push_back(patterns[i][`CPU_DATA_WIDTH-1:0]);
			end
		end
	endtask

	always @(posedge clk50MHz) begin
		if (wasReset && !reset && (halted !== 1'b0 || outStrobe !== 1'b0)) begin
			$display("Error: halted or outStrobe is not low after reset");
			errorCount++;
		end
		if (startStrobe && !reset) begin
			progNum++;
			outIndex = 0;
			testName = $sformatf("program %0d", progNum);
			collectExpected(progNum);
		end
		if (outStrobe === 1'b1) begin
			if (wasHalted) begin
				$display("Error: %s produced an output after HALT", testName);
				errorCount++;
			end else if (expected.size() == 0) begin
				$display("Error: %s produced an extra output %h", testName, outData);
				errorCount++;
			end else begin
				if (outData !== expected[0]) begin
					$display("FAIL %s output %0d: expected %h, actual %h",
						testName, outIndex, expected[0], outData);
					errorCount++;
				end
				expected.delete(0);
				outIndex++;
			end
		end
		// Halt rising ends the program's output list
		if (halted && !wasHalted && expected.size() != 0) begin
			$display("Error: %s halted with %0d outputs missing", testName, expected.size());
			errorCount++;
		end
		if (wasHalted && !halted && !wasReset) begin
			$display("Error: %s left the halt state without a reset", testName);
			errorCount++;
		end
		wasHalted <= halted;
		wasReset <= reset;
	end

endmodule

`default_nettype wire

// ==== tbCpu.sv ====
`default_nettype none
`include "cpu_cfg.svh"

module tbCpu;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClockPeriod = 100;

	logic                        clk50MHz;
	logic                        reset;
	logic                        loadStrobe;
	logic [`CPU_ADDR_WIDTH-1:0]  loadAddr;
	logic [`CPU_INSTR_WIDTH-1:0] loadData;
	logic                        startStrobe;
	wire                         outStrobe;
	wire  [`CPU_DATA_WIDTH-1:0]  outData;
	wire                         halted;
	int                          errorCount;
	logic [31:0]                 patterns [256];

	cpuTop uut (
		.clk50MHz(clk50MHz), .reset(reset), .loadStrobe(loadStrobe),
		.loadAddr(loadAddr), .loadData(loadData), .startStrobe(startStrobe),
		.outStrobe(outStrobe), .outData(outData), .halted(halted)
	);

	tbChecker check (
		.clk50MHz(clk50MHz), .reset(reset), .startStrobe(startStrobe),
		.outStrobe(outStrobe), .outData(outData), .halted(halted),
		.errorCount(errorCount)
	);

	initial begin
		clk50MHz = 1'b0;
		forever #(ClockPeriod / 2) clk50MHz = ~clk50MHz;
	end

	task automatic applyReset();
		@(posedge clk50MHz);
		reset <= 1'b1;
		repeat (2) @(posedge clk50MHz);
		reset <= 1'b0;
	endtask

	task automatic loadWord(input logic [31:0] word);
		@(posedge clk50MHz);
		loadStrobe <= 1'b1;
		loadAddr <= word[27:20];
		loadData <= word[`CPU_INSTR_WIDTH-1:0];
		@(posedge clk50MHz);
		loadStrobe <= 1'b0;
	endtask

	// Random idle gap, start pulse, then wait for HALT and watch a few more cycles
	task automatic runProgram();
		repeat ($urandom_range(16, 1)) @(posedge clk50MHz);
		startStrobe <= 1'b1;
		@(posedge clk50MHz);
		startStrobe <= 1'b0;
		while (halted !== 1'b1) begin
			@(posedge clk50MHz);
		end
		repeat (8) @(posedge clk50MHz);
	endtask

	initial begin
		int totalBudget;
		int loadCount;
		int progCount;
		longint limitCycles;
		logic [3:0] kind;
		logic programOpen;

		reset = 1'b1;
		loadStrobe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		startStrobe = 1'b0;
		void'($urandom(32'hef2e));
		$readmemh("cpu_patterns.mem", patterns);

		totalBudget = 0;
		loadCount = 0;
		progCount = 0;
		for (int i = 0; i < 256; i++) begin
			kind = patterns[i][31:28];
			if ($isunknown(kind) || kind == 4'h0) begin
				break;
			end
			if (kind == 4'h1) begin
				totalBudget += int'(patterns[i][15:0]);
				progCount++;
			end else if (kind == 4'h2) begin
				loadCount++;
			end
		end

		// Up to 3 cycles per step, plus loads, resets, idle gaps and tail
		limitCycles = longint'(totalBudget) * 3 + loadCount * 2 + progCount * 40 + 20;
		fork
			begin
				#(limitCycles * ClockPeriod);
				$display("Timeout: the run did not finish within %0d cycles", limitCycles);
				$display("TB FAILED");
				$finish;
			end
		join_none

		programOpen = 1'b0;
		for (int i = 0; i < 256; i++) begin
			kind = patterns[i][31:28];
			if ($isunknown(kind) || kind == 4'h0) begin
				break;
			end
			if (kind == 4'h1) begin
				if (programOpen) begin
					runProgram();
				end
				applyReset();
				programOpen = 1'b1;
			end else if (kind == 4'h2) begin
				loadWord(patterns[i]);
			end
		end
		if (programOpen) begin
			runProgram();
		end

		repeat (2) @(posedge clk50MHz);
		$display("Run complete: %0d programs, %0d errors", progCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpu_patterns.mem ====
// Kind in the top nibble: 1 program header with step budget in the low 16 bits, 0 end
// 2 load with address in bits 27:20 and instruction in 17:0, 3 expected output value
// Program 1: add, sub, inc, dec, logic ops, LDI sign extension, BR on negative and carry
1000_001E
2_00_1C464 2_01_1C81E 2_02_00C48 2_03_380C0
2_04_05084 2_05_38100 2_06_34408 2_07_38040
2_08_3480A 2_09_38080 2_0A_21408 2_0B_38140
2_0C_25800 2_0D_38180 2_0E_1DFFB 2_0F_381C0
2_10_0A1C8 2_11_38200 2_12_0E448 2_13_38240
2_14_129C4 2_15_38280 2_16_3C000
3000_0082 3000_FFBA 3000_001E 3000_001F 3000_FFFF
3000_FFFB 3000_001A 3000_007E 3000_FF9F
// Program 2: XCH, MOV, ST and LD, JMP, BR on zero, carry, negative and overflow
1000_0028
2_00_1C5FF 2_01_1C807 2_02_18480 2_03_38040
2_04_38080 2_05_14C80 2_06_1D0C8 2_07_2C0D0
2_08_29410 2_09_38140 2_0A_380C0 2_0B_05844
2_0C_3400E 2_0D_38080 2_0E_34810 2_0F_38080
2_10_34412 2_11_38040 2_12_34C14 2_13_38180
2_14_1E4F0 2_15_2A824 2_16_22C28 2_17_34019
2_18_382C0 2_19_34C1B 2_1A_38080 2_1B_3001D
2_1C_38080 2_1D_38280 2_1E_3C000
// Data word read back by LD, then incremented to overflow
2_F0_07FFF
3000_0007 3000_01FF 3000_01FF 3000_01FF
3000_0007 3000_0000 3000_8000 3000_7FFF
0000_0000

// ==== all.f ====
+incdir+.
cpu_pkg.sv
alu.sv
registerFile.sv
mainMemory.sv
busRouter.sv
controlUnit.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbCpu -f all.f -o simCpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simCpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi
